// ==== hw/dot_pkg.sv ====
package dot_pkg;

    // matrix geometry
    localparam int MATRIX_N = 8;
    localparam int ROW_W    = 3;
    localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(MATRIX_N - 1);

    // shape level encoding, 0 and 5..7 blank
    localparam int LEVEL_W = 3;
    localparam logic [LEVEL_W-1:0] LEVEL_BLANK = LEVEL_W'(0);
    localparam logic [LEVEL_W-1:0] LEVEL_MAX   = LEVEL_W'(4);

    // clk cycles per row, small for sim
    localparam int SCAN_DIV   = 4;
    localparam int SCAN_CNT_W = $clog2(SCAN_DIV);
    localparam logic [SCAN_CNT_W-1:0] SCAN_LAST = SCAN_CNT_W'(SCAN_DIV - 1);

    // key must hold a new value this long
    localparam int DEB_CYCLES = 8;
    localparam int DEB_CNT_W  = $clog2(DEB_CYCLES);
    localparam logic [DEB_CNT_W-1:0] DEB_LAST = DEB_CNT_W'(DEB_CYCLES - 1);

    // whole frames per shape size
    localparam int FRAMES_PER_LEVEL = 2;
    localparam int FRAME_CNT_W      = $clog2(FRAMES_PER_LEVEL + 1);
    localparam logic [FRAME_CNT_W-1:0] FRAME_LAST = FRAME_CNT_W'(FRAMES_PER_LEVEL - 1);

endpackage

// ==== hw/scan_tick_gen.sv ====
`timescale 1ns/1ns

module scan_tick_gen
(
    input  logic clk,
    input  logic rst,
    output logic scan_tick
);

    logic [dot_pkg::SCAN_CNT_W-1:0] div_cnt;

    // first strobe lands SCAN_DIV clocks out of reset
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt   <= '0;
            scan_tick <= 1'b0;
        end
        else if (div_cnt == dot_pkg::SCAN_LAST)
        begin
            div_cnt   <= '0;
            scan_tick <= 1'b1;
        end
        else
        begin
            div_cnt   <= div_cnt + 1'b1;
            scan_tick <= 1'b0;
        end
    end

endmodule

// ==== hw/key_debounce.sv ====
`timescale 1ns/1ns

module key_debounce
(
    input  logic clk,
    input  logic rst,
    input  logic key,
    output logic start_press
);

    logic key_meta;
    logic key_sync;
    logic key_level;    // accepted key state
    logic [dot_pkg::DEB_CNT_W-1:0] stable_cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            key_meta    <= 1'b0;
            key_sync    <= 1'b0;
            key_level   <= 1'b0;
            stable_cnt  <= '0;
            start_press <= 1'b0;
        end
        else
        begin
            key_meta    <= key;
            key_sync    <= key_meta;
            start_press <= 1'b0;

            if (key_sync == key_level)
                stable_cnt <= '0;   // bounce back, start over
            else if (stable_cnt == dot_pkg::DEB_LAST)
            begin
                key_level   <= key_sync;
                stable_cnt  <= '0;
                start_press <= key_sync; // pulse on accepted press only
            end
            else
                stable_cnt <= stable_cnt + 1'b1;
        end
    end

endmodule

// ==== hw/shape_seq.sv ====
`timescale 1ns/1ns

module shape_seq
(
    input  logic clk,
    input  logic rst,
    input  logic start_press,
    input  logic frame_start,
    output logic [dot_pkg::LEVEL_W-1:0] level
);

    logic pending;
    logic [dot_pkg::FRAME_CNT_W-1:0] frame_cnt;

    // press waits for a frame boundary
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pending <= 1'b0;
        else if (start_press)
            pending <= 1'b1;
        else if (frame_start)
            pending <= 1'b0;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            level     <= dot_pkg::LEVEL_BLANK;
            frame_cnt <= '0;
        end
        else if (frame_start)
        begin
            if (pending)
            begin
                level     <= dot_pkg::LEVEL_MAX;    // also restarts a running sequence
                frame_cnt <= '0;
            end
            else if (level != dot_pkg::LEVEL_BLANK)
            begin
                if (frame_cnt == dot_pkg::FRAME_LAST)
                begin
                    level     <= level - 1'b1;
                    frame_cnt <= '0;
                end
                else
                    frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hw/dz_matrix.sv ====
`timescale 1ns/1ns

module dz_matrix
(
    input  logic clk,
    input  logic rst,
    input  logic scan_tick,
    input  logic [dot_pkg::LEVEL_W-1:0] level,
    output logic frame_start,
    output logic [dot_pkg::MATRIX_N-1:0] row,
    output logic [dot_pkg::MATRIX_N-1:0] colr,
    output logic [dot_pkg::MATRIX_N-1:0] colg
);

    logic [dot_pkg::ROW_W-1:0] row_cnt;
    logic [dot_pkg::LEVEL_W-1:0] shown_level;  // fixed for a whole frame
    logic row_upd;
    logic [dot_pkg::MATRIX_N-1:0] row_next;
    logic [dot_pkg::MATRIX_N-1:0] col_q;

    // column pattern per shape size and row
    function automatic logic [dot_pkg::MATRIX_N-1:0] shape_row
    (
        input logic [dot_pkg::LEVEL_W-1:0] lvl,
        input logic [dot_pkg::ROW_W-1:0]   r
    );
        logic [dot_pkg::MATRIX_N-1:0] bits;
        bits = 8'h00;
        case (lvl)
            3'd4:
            begin
                case (r)
                    3'd2, 3'd5: bits = 8'h18;
                    3'd3, 3'd4: bits = 8'h3c;
                    default:    bits = 8'h00;
                endcase
            end
            3'd3:
            begin
                case (r)
                    3'd2, 3'd5: bits = 8'h38;
                    3'd3, 3'd4: bits = 8'h7c;
                    default:    bits = 8'h00;
                endcase
            end
            3'd2:
            begin
                case (r)
                    3'd2, 3'd5: bits = 8'h3c;
                    3'd3, 3'd4: bits = 8'h7e;
                    default:    bits = 8'h00;
                endcase
            end
            3'd1:
            begin
                case (r)
                    3'd1, 3'd6:             bits = 8'h3c;
                    3'd2, 3'd3, 3'd4, 3'd5: bits = 8'h7e;
                    default:                bits = 8'h00;
                endcase
            end
            default: bits = 8'h00;  // blank
        endcase
        return bits;
    endfunction

    assign frame_start = scan_tick && (row_cnt == dot_pkg::ROW_LAST);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_cnt     <= dot_pkg::ROW_LAST;   // first tick opens a frame
            shown_level <= dot_pkg::LEVEL_BLANK;
            row_upd     <= 1'b0;
        end
        else
        begin
            row_upd <= scan_tick;
            if (frame_start)
            begin
                row_cnt     <= '0;
                shown_level <= level;
            end
            else if (scan_tick)
                row_cnt <= row_cnt + 1'b1;
        end
    end

    // one active-low row line
    always_comb
    begin
        row_next          = '1;
        row_next[row_cnt] = 1'b0;
    end

    // outputs follow the counter by one cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row   <= '1;
            col_q <= '0;
        end
        else if (row_upd)
        begin
            row   <= row_next;
            col_q <= shape_row(shown_level, row_cnt);
        end
    end

    assign colr = col_q;
    assign colg = col_q;    // same pattern on both colours

endmodule

// ==== hw/dot_top.sv ====
`timescale 1ns/1ns

module dot_top
(
    input  logic clk,
    input  logic rst,
    input  logic key,   // raw start key, active high
    output logic [dot_pkg::MATRIX_N-1:0] row,
    output logic [dot_pkg::MATRIX_N-1:0] colr,
    output logic [dot_pkg::MATRIX_N-1:0] colg
);

    logic scan_tick;
    logic start_press;
    logic frame_start;
    logic [dot_pkg::LEVEL_W-1:0] level;

    scan_tick_gen i_scan_tick_gen
    (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick)
    );

    key_debounce i_key_debounce
    (
        .clk         (clk),
        .rst         (rst),
        .key         (key),
        .start_press (start_press)
    );

    shape_seq i_shape_seq
    (
        .clk         (clk),
        .rst         (rst),
        .start_press (start_press),
        .frame_start (frame_start),
        .level       (level)
    );

    dz_matrix i_dz_matrix
    (
        .clk         (clk),
        .rst         (rst),
        .scan_tick   (scan_tick),
        .level       (level),
        .frame_start (frame_start),
        .row         (row),
        .colr        (colr),
        .colg        (colg)
    );

endmodule

// ==== sim/tb_dot_top.sv ====
`timescale 1ns/1ns

module tb_dot_top;

    localparam int FRAME_CYC      = dot_pkg::MATRIX_N * dot_pkg::SCAN_DIV;
    localparam int RESET_CYC      = 3;
    localparam int IDLE_CYC       = 4 * FRAME_CYC;
    localparam int N_BURST        = 12;
    localparam int MAX_GAP        = 16;
    localparam int BURST_CYC      = N_BURST * (dot_pkg::DEB_CYCLES - 1 + MAX_GAP);
    localparam int SETTLE_CYC     = 2 * FRAME_CYC;
    localparam int MAX_EXTRA_HOLD = 3 * FRAME_CYC;
    localparam int RELEASE_CYC    = dot_pkg::DEB_CYCLES + 8;
    localparam int SHORT_HOLD     = dot_pkg::DEB_CYCLES + 4;
    localparam int SEQ_CYC        = (4 + int'(dot_pkg::LEVEL_MAX) * dot_pkg::FRAMES_PER_LEVEL)
                                    * FRAME_CYC;
    localparam int MAX_MID        = 6 * FRAME_CYC;
    localparam int POST_RESET_CYC = 4 * FRAME_CYC;
    localparam int TEST_CYC = RESET_CYC + IDLE_CYC + BURST_CYC + SETTLE_CYC
        + (dot_pkg::DEB_CYCLES + MAX_EXTRA_HOLD + RELEASE_CYC + SEQ_CYC)
        + (2 * (SHORT_HOLD + RELEASE_CYC) + MAX_MID + SEQ_CYC)
        + (SHORT_HOLD + RELEASE_CYC + MAX_MID + RESET_CYC + POST_RESET_CYC);
    localparam int CYCLE_LIMIT = TEST_CYC + TEST_CYC / 5;

    logic clk;
    logic rst;
    logic key;
    logic [dot_pkg::MATRIX_N-1:0] row;
    logic [dot_pkg::MATRIX_N-1:0] colr;
    logic [dot_pkg::MATRIX_N-1:0] colg;

    logic [31:0] lcg_state;
    int err_cnt;
    int check_cnt;
    int cycle_cnt;
    int lit_cnt;
    logic expect_blank;     // display must stay dark until a clean press

    // reference model state
    logic m_sync1, m_sync2, m_acc, m_press;
    logic m_pending, m_tick, m_upd;
    int m_run, m_level, m_frames, m_cyc, m_rowidx, m_shown;
    logic [7:0] m_row_out;
    logic [7:0] m_col;
    logic [7:0] prev_row;
    int hold_cnt;

    dot_top i_dut
    (
        .clk  (clk),
        .rst  (rst),
        .key  (key),
        .row  (row),
        .colr (colr),
        .colg (colg)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = next_rand();
        return lo + int'((r >> 8) % 32'(hi - lo + 1));
    endfunction

    // target shape table with one byte per row
    function automatic logic [7:0] expected_cols(input int lvl, input int r);
        logic [7:0] outer;      // rows 1 and 6
        logic [7:0] edge_bits;  // rows 2 and 5
        logic [7:0] centre;     // rows 3 and 4
        outer     = 8'h00;
        edge_bits = 8'h00;
        centre    = 8'h00;
        case (lvl)
            1:
            begin
                outer     = 8'h3c;
                edge_bits = 8'h7e;
                centre    = 8'h7e;
            end
            2:
            begin
                edge_bits = 8'h3c;
                centre    = 8'h7e;
            end
            3:
            begin
                edge_bits = 8'h38;
                centre    = 8'h7c;
            end
            4:
            begin
                edge_bits = 8'h18;
                centre    = 8'h3c;
            end
            default: outer = 8'h00;   // blank sizes
        endcase
        case (r)
            1, 6:    return outer;
            2, 5:    return edge_bits;
            3, 4:    return centre;
            default: return 8'h00;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [7:0] exp,
                                   input logic [7:0] act);
        err_cnt++;
        $display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
    endtask

    task automatic report_problem(input string msg);
        err_cnt++;
        $display("%s", msg);
    endtask

    task automatic check_reset_outputs();
        if (row !== 8'hff)
            report_mismatch("row", 8'hff, row);
        if (colr !== 8'h00)
            report_mismatch("colr", 8'h00, colr);
        if (colg !== 8'h00)
            report_mismatch("colg", 8'h00, colg);
    endtask

    task automatic check_outputs();
        check_cnt++;
        if (row !== m_row_out)
            report_mismatch("row", m_row_out, row);
        if (colr !== m_col)
            report_mismatch("colr", m_col, colr);
        if (colg !== m_col)
            report_mismatch("colg", m_col, colg);
        if (row != 8'hff && $countones(~row) != 1)
            report_problem($sformatf("row %h does not have exactly one line low", row));
        if (expect_blank && colr !== 8'h00)
            report_problem($sformatf("shape lit at %0t without a clean press", $time));
        if (colr != 8'h00)
            lit_cnt++;
        if (row == prev_row)
            hold_cnt++;
        else
        begin
            if (prev_row != 8'hff && row != 8'hff && hold_cnt != dot_pkg::SCAN_DIV)
                report_problem($sformatf("row %h held %0d clocks instead of %0d",
                                         prev_row, hold_cnt, dot_pkg::SCAN_DIV));
            prev_row = row;
            hold_cnt = 1;
        end
    endtask

    // compare first and then advance the model by one clock
    always @(posedge clk or posedge rst)
    begin : model_step
        logic fs;
        if (rst)
        begin
            {m_sync1, m_sync2, m_acc, m_press} = 4'b0000;
            {m_pending, m_tick, m_upd} = 3'b000;
            m_run     = 0;
            m_level   = 0;
            m_frames  = 0;
            m_cyc     = 0;
            m_rowidx  = dot_pkg::MATRIX_N - 1;   // first tick opens row 0
            m_shown   = 0;
            m_row_out = 8'hff;
            m_col     = 8'h00;
            prev_row  = 8'hff;
            hold_cnt  = 0;
        end
        else
        begin
            check_outputs();
            fs = m_tick && (m_rowidx == dot_pkg::MATRIX_N - 1);
            if (m_upd)
            begin
                m_row_out = ~(8'h01 << m_rowidx);
                m_col     = expected_cols(m_shown, m_rowidx);
            end
            m_upd = m_tick;
            if (m_tick)
                m_rowidx = (m_rowidx + 1) % dot_pkg::MATRIX_N;
            if (fs)
            begin
                m_shown = m_level;  // new level visible one frame later
                if (m_pending)
                begin
                    m_level  = int'(dot_pkg::LEVEL_MAX);
                    m_frames = 0;
                end
                else if (m_level != 0)
                begin
                    m_frames++;
                    if (m_frames == dot_pkg::FRAMES_PER_LEVEL)
                    begin
                        m_level--;
                        m_frames = 0;
                    end
                end
            end
            if (m_press)
                m_pending = 1'b1;
            else if (fs)
                m_pending = 1'b0;
            m_press = 1'b0;
            if (m_sync2 != m_acc)
            begin
                m_run++;
                if (m_run == dot_pkg::DEB_CYCLES)
                begin
                    m_acc   = m_sync2;
                    m_press = m_sync2;
                    m_run   = 0;
                end
            end
            else
                m_run = 0;
            m_sync2 = m_sync1;
            m_sync1 = key;
            m_cyc++;
            m_tick = (m_cyc % dot_pkg::SCAN_DIV == 0);
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic press_key(input int hold);
        key = 1'b1;
        wait_cycles(hold);
        key = 1'b0;
        wait_cycles(RELEASE_CYC);
    endtask

    task automatic report_and_finish();
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    endtask

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run went past %0d clock cycles", CYCLE_LIMIT);
        err_cnt++;
        report_and_finish();
    end

    initial
    begin : stimulus
        int lit_before;
        lcg_state    = 32'hc0ea06b8;
        err_cnt      = 0;
        check_cnt    = 0;
        lit_cnt      = 0;
        expect_blank = 1'b1;
        rst          = 1'b1;
        key          = 1'b0;
        repeat (RESET_CYC)
        begin
            @(negedge clk);
            check_reset_outputs();
        end
        rst = 1'b0;
        wait_cycles(IDLE_CYC);

        // short bounces that must not be accepted
        for (int i = 0; i < N_BURST; i++)
        begin
            key = 1'b1;
            wait_cycles(rand_range(1, dot_pkg::DEB_CYCLES - 1));
            key = 1'b0;
            wait_cycles(rand_range(1, MAX_GAP));
        end
        wait_cycles(SETTLE_CYC);

        expect_blank = 1'b0;
        lit_before = lit_cnt;
        press_key(rand_range(dot_pkg::DEB_CYCLES, dot_pkg::DEB_CYCLES + MAX_EXTRA_HOLD));
        wait_cycles(SEQ_CYC);
        if (lit_cnt == lit_before)
            report_problem("no shape shown after a clean press");
        if (colr !== 8'h00)
            report_problem("display not blank after the sequence ran out");

        // restart partway through
        press_key(SHORT_HOLD);
        wait_cycles(rand_range(2 * FRAME_CYC, MAX_MID));
        press_key(SHORT_HOLD);
        wait_cycles(SEQ_CYC);

        // async reset mid-run
        press_key(SHORT_HOLD);
        wait_cycles(rand_range(2 * FRAME_CYC, MAX_MID));
        rst = 1'b1;
        expect_blank = 1'b1;
        #1;
        check_reset_outputs();
        repeat (RESET_CYC)
        begin
            @(negedge clk);
            check_reset_outputs();
        end
        rst = 1'b0;
        wait_cycles(POST_RESET_CYC);
        report_and_finish();
    end

endmodule

// ==== dot_top.f ====
hw/dot_pkg.sv
hw/scan_tick_gen.sv
hw/key_debounce.sv
hw/shape_seq.sv
hw/dz_matrix.sv
hw/dot_top.sv
sim/tb_dot_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_dot_top -o tb_dot_top -f dot_top.f \
    && ./obj_dir/tb_dot_top > sim.log 2>&1 \
    || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "test passed" sim.log && echo "simulation ok" || { echo "simulation not ok"; exit 1; }
